//--- hdl/sram_tester_pkg.sv
`default_nettype none

package sram_tester_pkg;

  localparam int ADDR_BITS = 6;
  localparam int DATA_BITS = 16;
  localparam int NUM_WORDS = 2 ** ADDR_BITS;

  localparam int CMD_FIFO_DEPTH = 4;
  localparam int RSP_FIFO_DEPTH = 4;
  // oe_n low to data sample, in clocks
  localparam int SRAM_READ_CYCLES = 2;
  localparam int NUM_PATTERNS = 5;

  localparam int CMD_CREDIT_BITS = $clog2(CMD_FIFO_DEPTH + 1);
  localparam int RSP_CREDIT_BITS = $clog2(RSP_FIFO_DEPTH + 1);
  localparam int WAIT_BITS = $clog2(SRAM_READ_CYCLES + 1);

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [DATA_BITS-1:0] data_word_t;
  typedef logic [CMD_CREDIT_BITS-1:0] cmd_credit_t;
  typedef logic [RSP_CREDIT_BITS-1:0] rsp_credit_t;
  typedef logic [WAIT_BITS-1:0] wait_t;

  // order here is the test order
  typedef enum logic [2:0] {
    PAT_ZEROS = 3'd0,
    PAT_ONES  = 3'd1,
    PAT_5555  = 3'd2,
    PAT_AAAA  = 3'd3,
    PAT_ADDR  = 3'd4
  } pattern_t;

  typedef struct packed {
    logic       we;
    addr_t      addr;
    data_word_t data;
    pattern_t   pattern;
    logic       last;
  } sram_cmd_t;

  typedef struct packed {
    addr_t      addr;
    data_word_t data;
    data_word_t expected;
    pattern_t   pattern;
    logic       last;
  } sram_rsp_t;

  function automatic data_word_t pattern_word(pattern_t pat, addr_t addr);
    case (pat)
      PAT_ZEROS: return '0;
      PAT_ONES:  return '1;
      PAT_5555:  return {(DATA_BITS / 2) {2'b01}};
      PAT_AAAA:  return {(DATA_BITS / 2) {2'b10}};
      PAT_ADDR:  return data_word_t'(addr);
      default:   return '0;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- hdl/credit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int DEPTH = 4
) (
  input  logic     CLK,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     full,
  output logic     credit
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  payload_t            mem[DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                do_push;
  logic                do_pop;

  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign empty    = (count == '0);
  assign full     = (count == CNT_BITS'(DEPTH));
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      // one credit back to the sender per word that leaves
      credit <= do_pop;
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/test_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module test_sequencer (
  input  logic                        CLK,
  input  logic                        reset,
  input  logic                        cmd_credit,
  output logic                        cmd_valid,
  output logic                        cmd_we,
  output sram_tester_pkg::addr_t      cmd_addr,
  output sram_tester_pkg::data_word_t cmd_data,
  output sram_tester_pkg::pattern_t   cmd_pattern,
  output logic                        cmd_last
);

  sram_tester_pkg::pattern_t    pattern_q;
  sram_tester_pkg::addr_t       addr_q;
  sram_tester_pkg::cmd_credit_t credits;
  logic                         reading;
  logic                         issue;
  logic                         addr_wrap;
  logic                         last_cmd;

  assign issue     = (credits != '0);
  assign addr_wrap = (addr_q == sram_tester_pkg::addr_t'(sram_tester_pkg::NUM_WORDS - 1));
  // final read of the address pattern closes the round
  assign last_cmd  = reading && addr_wrap && (pattern_q == sram_tester_pkg::PAT_ADDR);

  always_ff @(posedge CLK) begin
    if (reset) begin
      cmd_valid <= 1'b0;
      credits   <= sram_tester_pkg::cmd_credit_t'(sram_tester_pkg::CMD_FIFO_DEPTH);
      pattern_q <= sram_tester_pkg::PAT_ZEROS;
      addr_q    <= '0;
      reading   <= 1'b0;
    end else begin
      cmd_valid <= issue;
      if (issue && !cmd_credit) begin
        credits <= credits - 1'b1;
      end else if (!issue && cmd_credit) begin
        credits <= credits + 1'b1;
      end
      // stall in place without a credit
      if (issue) begin
        if (addr_wrap) begin
          addr_q  <= '0;
          reading <= !reading;
          if (reading) begin
            if (pattern_q == sram_tester_pkg::pattern_t'(sram_tester_pkg::NUM_PATTERNS - 1)) begin
              pattern_q <= sram_tester_pkg::PAT_ZEROS;
            end else begin
              pattern_q <= sram_tester_pkg::pattern_t'(pattern_q + 1'b1);
            end
          end
        end else begin
          addr_q <= addr_q + 1'b1;
        end
      end
    end
  end

  // for reads the data field is the expected word
  always_ff @(posedge CLK) begin
    if (issue) begin
      cmd_we      <= !reading;
      cmd_addr    <= addr_q;
      cmd_data    <= sram_tester_pkg::pattern_word(pattern_q, addr_q);
      cmd_pattern <= pattern_q;
      cmd_last    <= last_cmd;
    end
  end

endmodule

`default_nettype wire

//--- hdl/sram_controller.sv
`timescale 1ns/1ps
`default_nettype none

module sram_controller (
  input  logic                        CLK,
  input  logic                        reset,
  input  logic                        cmd_valid,
  input  logic                        cmd_we,
  input  sram_tester_pkg::addr_t      cmd_addr,
  input  sram_tester_pkg::data_word_t cmd_data,
  input  sram_tester_pkg::pattern_t   cmd_pattern,
  input  logic                        cmd_last,
  output logic                        cmd_credit,
  input  logic                        rsp_credit,
  output logic                        rsp_valid,
  output sram_tester_pkg::addr_t      rsp_addr,
  output sram_tester_pkg::data_word_t rsp_data,
  output sram_tester_pkg::data_word_t rsp_expected,
  output sram_tester_pkg::pattern_t   rsp_pattern,
  output logic                        rsp_last,
  output sram_tester_pkg::addr_t      sram_addr,
  output sram_tester_pkg::data_word_t sram_dq_out,
  output logic                        sram_dq_oe,
  input  sram_tester_pkg::data_word_t sram_dq_in,
  output logic                        sram_ce_n,
  output logic                        sram_oe_n,
  output logic                        sram_we_n
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_SETUP,
    ST_WR_PULSE,
    ST_WR_HOLD,
    ST_RD_WAIT
  } state_t;

  state_t                       state;
  sram_tester_pkg::sram_cmd_t   cmd_in;
  sram_tester_pkg::sram_cmd_t   head;
  sram_tester_pkg::sram_cmd_t   cur;
  sram_tester_pkg::rsp_credit_t rsp_credits;
  sram_tester_pkg::wait_t       wait_cnt;
  logic                         cmd_empty;
  logic                         can_pop;
  logic                         spend;
  logic                         sample;

  assign cmd_in = '{
    we: cmd_we,
    addr: cmd_addr,
    data: cmd_data,
    pattern: cmd_pattern,
    last: cmd_last
  };

  credit_fifo #(
    .payload_t(sram_tester_pkg::sram_cmd_t),
    .DEPTH    (sram_tester_pkg::CMD_FIFO_DEPTH)
  ) cmd_fifo_i (
    .CLK      (CLK),
    .reset    (reset),
    .push     (cmd_valid),
    .push_data(cmd_in),
    .pop      (can_pop),
    .pop_data (head),
    .empty    (cmd_empty),
    .full     (),
    .credit   (cmd_credit)
  );

  // a read waits at the head until the checker has room for its response
  assign can_pop = (state == ST_IDLE) && !cmd_empty && (head.we || rsp_credits != '0);
  assign spend   = can_pop && !head.we;
  assign sample  = (state == ST_RD_WAIT) && (wait_cnt == '0);

  always_ff @(posedge CLK) begin
    if (reset) begin
      state       <= ST_IDLE;
      sram_ce_n   <= 1'b1;
      sram_oe_n   <= 1'b1;
      sram_we_n   <= 1'b1;
      sram_dq_oe  <= 1'b0;
      rsp_valid   <= 1'b0;
      wait_cnt    <= '0;
      rsp_credits <= sram_tester_pkg::rsp_credit_t'(sram_tester_pkg::RSP_FIFO_DEPTH);
    end else begin
      rsp_valid <= sample;
      if (spend && !rsp_credit) begin
        rsp_credits <= rsp_credits - 1'b1;
      end else if (!spend && rsp_credit) begin
        rsp_credits <= rsp_credits + 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (can_pop) begin
            sram_ce_n <= 1'b0;
            if (head.we) begin
              sram_dq_oe <= 1'b1;
              state      <= ST_WR_SETUP;
            end else begin
              sram_oe_n <= 1'b0;
              wait_cnt  <= sram_tester_pkg::wait_t'(sram_tester_pkg::SRAM_READ_CYCLES - 1);
              state     <= ST_RD_WAIT;
            end
          end
        end
        ST_WR_SETUP: begin
          sram_we_n <= 1'b0;
          state     <= ST_WR_PULSE;
        end
        ST_WR_PULSE: begin
          sram_we_n <= 1'b1;
          state     <= ST_WR_HOLD;
        end
        // data held one cycle past the rising we_n
        ST_WR_HOLD: begin
          sram_ce_n  <= 1'b1;
          sram_dq_oe <= 1'b0;
          state      <= ST_IDLE;
        end
        ST_RD_WAIT: begin
          if (wait_cnt == '0) begin
            sram_ce_n <= 1'b1;
            sram_oe_n <= 1'b1;
            state     <= ST_IDLE;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (can_pop) begin
      sram_addr   <= head.addr;
      sram_dq_out <= head.data;
      cur         <= head;
    end
    if (sample) begin
      rsp_addr     <= cur.addr;
      rsp_data     <= sram_dq_in;
      rsp_expected <= cur.data;
      rsp_pattern  <= cur.pattern;
      rsp_last     <= cur.last;
    end
  end

endmodule

`default_nettype wire

//--- hdl/result_checker.sv
`timescale 1ns/1ps
`default_nettype none

module result_checker (
  input  logic                        CLK,
  input  logic                        reset,
  input  logic                        rsp_valid,
  input  sram_tester_pkg::addr_t      rsp_addr,
  input  sram_tester_pkg::data_word_t rsp_data,
  input  sram_tester_pkg::data_word_t rsp_expected,
  input  sram_tester_pkg::pattern_t   rsp_pattern,
  input  logic                        rsp_last,
  output logic                        rsp_credit,
  output logic                        test_done,
  output logic                        test_pass,
  output sram_tester_pkg::data_word_t fail_expected,
  output sram_tester_pkg::data_word_t fail_read,
  output sram_tester_pkg::addr_t      fail_addr,
  output sram_tester_pkg::pattern_t   fail_pattern
);

  sram_tester_pkg::sram_rsp_t rsp_in;
  sram_tester_pkg::sram_rsp_t head;
  sram_tester_pkg::sram_rsp_t cmp_rsp;
  logic                       rsp_empty;
  logic                       pop;
  logic                       cmp_fail;
  logic                       cmp_last;

  assign rsp_in = '{
    addr: rsp_addr,
    data: rsp_data,
    expected: rsp_expected,
    pattern: rsp_pattern,
    last: rsp_last
  };

  credit_fifo #(
    .payload_t(sram_tester_pkg::sram_rsp_t),
    .DEPTH    (sram_tester_pkg::RSP_FIFO_DEPTH)
  ) rsp_fifo_i (
    .CLK      (CLK),
    .reset    (reset),
    .push     (rsp_valid),
    .push_data(rsp_in),
    .pop      (pop),
    .pop_data (head),
    .empty    (rsp_empty),
    .full     (),
    .credit   (rsp_credit)
  );

  // drain one response per cycle
  assign pop = !rsp_empty;

  always_ff @(posedge CLK) begin
    if (reset) begin
      cmp_fail  <= 1'b0;
      cmp_last  <= 1'b0;
      test_done <= 1'b0;
      test_pass <= 1'b1;
    end else begin
      cmp_fail  <= pop && (head.data != head.expected);
      cmp_last  <= pop && head.last;
      test_done <= cmp_last;
      // sticky until the next reset
      if (cmp_fail) begin
        test_pass <= 1'b0;
      end
    end
  end

  // only the first mismatch is kept
  always_ff @(posedge CLK) begin
    if (pop) begin
      cmp_rsp <= head;
    end
    if (cmp_fail && test_pass) begin
      fail_expected <= cmp_rsp.expected;
      fail_read     <= cmp_rsp.data;
      fail_addr     <= cmp_rsp.addr;
      fail_pattern  <= cmp_rsp.pattern;
    end
  end

endmodule

`default_nettype wire

//--- hdl/status_display.sv
`timescale 1ns/1ps
`default_nettype none

module status_display (
  input  logic                        CLK,
  input  logic                        reset,
  input  logic                        test_done,
  input  logic                        test_pass,
  input  sram_tester_pkg::addr_t      live_addr,
  input  sram_tester_pkg::pattern_t   live_pattern,
  input  sram_tester_pkg::data_word_t fail_expected,
  input  sram_tester_pkg::data_word_t fail_read,
  input  sram_tester_pkg::addr_t      fail_addr,
  input  sram_tester_pkg::pattern_t   fail_pattern,
  output logic                        led_done,
  output logic                        led_pass,
  output logic [7:0]                  debug_e,
  output logic [7:0]                  debug_f,
  output logic [7:0]                  debug_h,
  output logic [7:0]                  debug_i,
  output logic [7:0]                  debug_j
);

  sram_tester_pkg::addr_t    addr_q;
  sram_tester_pkg::pattern_t shown_pattern;
  logic [7:0]                addr_rev;

  // mirror the low width bits of value
  function automatic logic [7:0] reverse_bits(logic [7:0] value, int width);
    logic [7:0] result;
    result = '0;
    for (int i = 0; i < width; i++) begin
      result[i] = value[width-1-i];
    end
    return result;
  endfunction

  always_ff @(posedge CLK) begin
    if (reset) begin
      addr_q <= '0;
    end else begin
      addr_q <= test_pass ? live_addr : fail_addr;
    end
  end

  assign shown_pattern = test_pass ? live_pattern : fail_pattern;
  assign addr_rev      = reverse_bits(8'(addr_q), sram_tester_pkg::ADDR_BITS);

  assign led_done = test_done;
  assign led_pass = test_pass;

  assign debug_e = reverse_bits(8'(shown_pattern), $bits(sram_tester_pkg::pattern_t));
  // upper half of the reversed address on f, lower half on h
  assign debug_f = 8'(addr_rev[sram_tester_pkg::ADDR_BITS-1:sram_tester_pkg::ADDR_BITS/2]);
  assign debug_h = 8'(addr_rev[sram_tester_pkg::ADDR_BITS/2-1:0]);
  assign debug_i = test_pass ? 8'(addr_q) : fail_expected[7:0];
  assign debug_j = test_pass ? 8'h00 : fail_read[7:0];

endmodule

`default_nettype wire

//--- hdl/sram_tester_top.sv
`timescale 1ns/1ps
`default_nettype none

module sram_tester_top (
  input  logic                        CLK,
  input  logic                        reset,
  output sram_tester_pkg::addr_t      sram_addr,
  output sram_tester_pkg::data_word_t sram_dq_out,
  output logic                        sram_dq_oe,
  input  sram_tester_pkg::data_word_t sram_dq_in,
  output logic                        sram_ce_n,
  output logic                        sram_oe_n,
  output logic                        sram_we_n,
  output logic                        led_done,
  output logic                        led_pass,
  output logic [7:0]                  debug_e,
  output logic [7:0]                  debug_f,
  output logic [7:0]                  debug_h,
  output logic [7:0]                  debug_i,
  output logic [7:0]                  debug_j
);

  // sequencer to controller
  logic                        cmd_valid;
  logic                        cmd_we;
  sram_tester_pkg::addr_t      cmd_addr;
  sram_tester_pkg::data_word_t cmd_data;
  sram_tester_pkg::pattern_t   cmd_pattern;
  logic                        cmd_last;
  logic                        cmd_credit;

  // controller to checker
  logic                        rsp_valid;
  sram_tester_pkg::addr_t      rsp_addr;
  sram_tester_pkg::data_word_t rsp_data;
  sram_tester_pkg::data_word_t rsp_expected;
  sram_tester_pkg::pattern_t   rsp_pattern;
  logic                        rsp_last;
  logic                        rsp_credit;

  // checker to display
  logic                        test_done;
  logic                        test_pass;
  sram_tester_pkg::data_word_t fail_expected;
  sram_tester_pkg::data_word_t fail_read;
  sram_tester_pkg::addr_t      fail_addr;
  sram_tester_pkg::pattern_t   fail_pattern;

  test_sequencer sequencer_i (
    .CLK        (CLK),
    .reset      (reset),
    .cmd_credit (cmd_credit),
    .cmd_valid  (cmd_valid),
    .cmd_we     (cmd_we),
    .cmd_addr   (cmd_addr),
    .cmd_data   (cmd_data),
    .cmd_pattern(cmd_pattern),
    .cmd_last   (cmd_last)
  );

  sram_controller controller_i (
    .CLK         (CLK),
    .reset       (reset),
    .cmd_valid   (cmd_valid),
    .cmd_we      (cmd_we),
    .cmd_addr    (cmd_addr),
    .cmd_data    (cmd_data),
    .cmd_pattern (cmd_pattern),
    .cmd_last    (cmd_last),
    .cmd_credit  (cmd_credit),
    .rsp_credit  (rsp_credit),
    .rsp_valid   (rsp_valid),
    .rsp_addr    (rsp_addr),
    .rsp_data    (rsp_data),
    .rsp_expected(rsp_expected),
    .rsp_pattern (rsp_pattern),
    .rsp_last    (rsp_last),
    .sram_addr   (sram_addr),
    .sram_dq_out (sram_dq_out),
    .sram_dq_oe  (sram_dq_oe),
    .sram_dq_in  (sram_dq_in),
    .sram_ce_n   (sram_ce_n),
    .sram_oe_n   (sram_oe_n),
    .sram_we_n   (sram_we_n)
  );

  result_checker checker_i (
    .CLK          (CLK),
    .reset        (reset),
    .rsp_valid    (rsp_valid),
    .rsp_addr     (rsp_addr),
    .rsp_data     (rsp_data),
    .rsp_expected (rsp_expected),
    .rsp_pattern  (rsp_pattern),
    .rsp_last     (rsp_last),
    .rsp_credit   (rsp_credit),
    .test_done    (test_done),
    .test_pass    (test_pass),
    .fail_expected(fail_expected),
    .fail_read    (fail_read),
    .fail_addr    (fail_addr),
    .fail_pattern (fail_pattern)
  );

  // live address and pattern come straight from the sequencer
  status_display display_i (
    .CLK          (CLK),
    .reset        (reset),
    .test_done    (test_done),
    .test_pass    (test_pass),
    .live_addr    (cmd_addr),
    .live_pattern (cmd_pattern),
    .fail_expected(fail_expected),
    .fail_read    (fail_read),
    .fail_addr    (fail_addr),
    .fail_pattern (fail_pattern),
    .led_done     (led_done),
    .led_pass     (led_pass),
    .debug_e      (debug_e),
    .debug_f      (debug_f),
    .debug_h      (debug_h),
    .debug_i      (debug_i),
    .debug_j      (debug_j)
  );

endmodule

`default_nettype wire

//--- tb/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sram_model (
  input  sram_tester_pkg::addr_t      addr,
  input  sram_tester_pkg::data_word_t din,
  input  logic                        din_oe,
  output sram_tester_pkg::data_word_t dout,
  input  logic                        ce_n,
  input  logic                        oe_n,
  input  logic                        we_n,
  input  logic                        fault_en,
  input  sram_tester_pkg::addr_t      fault_addr,
  input  logic [3:0]                  fault_bit
);

  sram_tester_pkg::data_word_t mem[sram_tester_pkg::NUM_WORDS];
  sram_tester_pkg::data_word_t stuck_mask;

  // fill depends on the whole address
  initial begin
    for (int i = 0; i < sram_tester_pkg::NUM_WORDS; i++) begin
      mem[i] = sram_tester_pkg::data_word_t'(i * 16'h0101) ^ 16'hc3a5;
    end
  end

  // word is latched when we_n rises
  always @(posedge we_n) begin
    if (!ce_n && din_oe) begin
      mem[addr] <= din;
    end
  end

  // stuck-at-1 cell shows up on every read of that address
  assign stuck_mask = (fault_en && addr == fault_addr) ?
                      (sram_tester_pkg::data_word_t'(1) << fault_bit) : '0;

  assign dout = (!ce_n && !oe_n) ? (mem[addr] | stuck_mask) : '0;

endmodule

`default_nettype wire

//--- tb/sram_tester_props.sv
`timescale 1ns/1ps
`default_nettype none

module sram_tester_props #(
  parameter bit PIN_CHECKS = 1'b1
) (
  input logic CLK,
  input logic reset,
  input logic we_n,
  input logic oe_n,
  input logic dq_oe,
  input logic push,
  input logic full
);

  if (PIN_CHECKS) begin : pin_checks
    // bus contention on the SRAM pins
    we_oe_exclusive: assert property (@(posedge CLK) disable iff (reset) !(!we_n && !oe_n))
      else $error("we_n and oe_n low together");

    dq_oe_not_reading: assert property (@(posedge CLK) disable iff (reset) !(dq_oe && !oe_n))
      else $error("data driven while SRAM output enabled");
  end else begin : fifo_checks
    // credits must keep the FIFOs from overflowing
    no_push_full: assert property (@(posedge CLK) disable iff (reset) !(push && full))
      else $error("FIFO push while full");
  end

endmodule

bind sram_tester_top sram_tester_props #(.PIN_CHECKS(1'b1)) pin_props_i (
  .CLK  (CLK),
  .reset(reset),
  .we_n (sram_we_n),
  .oe_n (sram_oe_n),
  .dq_oe(sram_dq_oe),
  .push (1'b0),
  .full (1'b0)
);

bind credit_fifo sram_tester_props #(.PIN_CHECKS(1'b0)) fifo_props_i (
  .CLK  (CLK),
  .reset(reset),
  .we_n (1'b1),
  .oe_n (1'b1),
  .dq_oe(1'b0),
  .push (push),
  .full (full)
);

`default_nettype wire

//--- tb/sram_tester_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sram_tester_tb;

  localparam int ROUND_CYCLES = sram_tester_pkg::NUM_PATTERNS * 2 * sram_tester_pkg::NUM_WORDS * 6;
  // two clean rounds, the fault round and the recovery round
  localparam int NUM_ROUNDS = 4;
  localparam int CYCLE_LIMIT = NUM_ROUNDS * ROUND_CYCLES + 1000;
  // one read per word and pattern in each round
  localparam int ROUND_READS = sram_tester_pkg::NUM_PATTERNS * sram_tester_pkg::NUM_WORDS;

  logic                        CLK;
  logic                        reset;
  sram_tester_pkg::addr_t      sram_addr;
  sram_tester_pkg::data_word_t sram_dq_out;
  sram_tester_pkg::data_word_t sram_dq_in;
  logic                        sram_dq_oe;
  logic                        sram_ce_n;
  logic                        sram_oe_n;
  logic                        sram_we_n;
  logic                        led_done;
  logic                        led_pass;
  logic [7:0]                  debug_e;
  logic [7:0]                  debug_f;
  logic [7:0]                  debug_h;
  logic [7:0]                  debug_i;
  logic [7:0]                  debug_j;
  logic                        fault_en;
  sram_tester_pkg::addr_t      fault_addr;
  logic [3:0]                  fault_bit;

  int                          errors;
  int                          tests_run;
  int                          tests_bad;
  int                          cycles;
  int unsigned                 lcg_state;
  int                          reads_in_round;
  int                          round_reads[$];
  logic                        prev_oe_n;
  logic                        prev_we_n;
  bit                          snap_taken;
  logic [7:0]                  snap_pattern;
  sram_tester_pkg::data_word_t snap[sram_tester_pkg::NUM_WORDS];

  sram_tester_top dut_i (
    .CLK(CLK), .reset(reset),
    .sram_addr(sram_addr), .sram_dq_out(sram_dq_out), .sram_dq_oe(sram_dq_oe),
    .sram_dq_in(sram_dq_in), .sram_ce_n(sram_ce_n), .sram_oe_n(sram_oe_n),
    .sram_we_n(sram_we_n), .led_done(led_done), .led_pass(led_pass),
    .debug_e(debug_e), .debug_f(debug_f), .debug_h(debug_h),
    .debug_i(debug_i), .debug_j(debug_j)
  );

  sram_model mem_i (
    .addr(sram_addr), .din(sram_dq_out), .din_oe(sram_dq_oe), .dout(sram_dq_in),
    .ce_n(sram_ce_n), .oe_n(sram_oe_n), .we_n(sram_we_n),
    .fault_en(fault_en), .fault_addr(fault_addr), .fault_bit(fault_bit)
  );

  always #2 CLK = ~CLK;

  function automatic int unsigned lcg_next(int unsigned s);
    return (s * 32'd1103515245 + 32'd12345) & 32'h7fffffff;
  endfunction

  // word written for pattern index p at address a
  function automatic sram_tester_pkg::data_word_t pattern_ref(int p, sram_tester_pkg::addr_t a);
    case (p)
      0: return 16'h0000;
      1: return 16'hffff;
      2: return 16'h5555;
      3: return 16'haaaa;
      default: return {10'b0, a};
    endcase
  endfunction

  // debug_e shows the 3-bit pattern index mirrored
  function automatic logic [7:0] mirrored_pattern(int p);
    logic [2:0] idx;
    idx = 3'(p);
    return {5'b0, idx[0], idx[1], idx[2]};
  endfunction

  // first read in test order that differs because of the stuck bit
  function automatic void first_fail_ref(input sram_tester_pkg::addr_t fa, input int fb,
                                         output sram_tester_pkg::addr_t addr,
                                         output sram_tester_pkg::data_word_t exp,
                                         output sram_tester_pkg::data_word_t rd);
    sram_tester_pkg::data_word_t word;
    addr = '0;
    exp = '0;
    rd = '0;
    for (int p = sram_tester_pkg::NUM_PATTERNS - 1; p >= 0; p--) begin
      word = pattern_ref(p, fa);
      if ((word | (16'h1 << fb)) != word) begin
        addr = fa;
        exp = word;
        rd = word | (16'h1 << fb);
      end
    end
  endfunction

  // debug_f holds the upper half of the reversed address
  function automatic sram_tester_pkg::addr_t decode_addr(logic [7:0] f, logic [7:0] h);
    logic [sram_tester_pkg::ADDR_BITS-1:0] rev;
    sram_tester_pkg::addr_t a;
    rev = {f[sram_tester_pkg::ADDR_BITS/2-1:0], h[sram_tester_pkg::ADDR_BITS/2-1:0]};
    for (int i = 0; i < sram_tester_pkg::ADDR_BITS; i++) begin
      a[i] = rev[sram_tester_pkg::ADDR_BITS-1-i];
    end
    return a;
  endfunction

  task automatic check_word(string name, sram_tester_pkg::data_word_t exp,
                            sram_tester_pkg::data_word_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(string name, sram_tester_pkg::addr_t exp,
                            sram_tester_pkg::addr_t act);
    if (exp !== act) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(string name, bit exp, logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic end_test(string name, int errors_before);
    tests_run++;
    if (errors != errors_before) begin
      tests_bad++;
      $display("test %s: FAILED", name);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (8) @(negedge CLK);
    reset = 1'b0;
  endtask

  task automatic wait_done();
    do @(negedge CLK); while (!led_done);
  endtask

  // reads per round, and a copy of memory when the address pattern write pass ends
  always @(negedge CLK) begin
    if (reset) begin
      reads_in_round = 0;
      round_reads.delete();
      prev_oe_n = 1'b1;
      prev_we_n = 1'b1;
    end else begin
      if (prev_oe_n && !sram_oe_n) begin
        reads_in_round++;
      end
      if (led_done) begin
        round_reads.push_back(reads_in_round);
        reads_in_round = 0;
      end
      if (!snap_taken && !prev_we_n && sram_we_n &&
          sram_addr == sram_tester_pkg::addr_t'(sram_tester_pkg::NUM_WORDS - 1) &&
          sram_dq_out == pattern_ref(4, sram_addr)) begin
        for (int i = 0; i < sram_tester_pkg::NUM_WORDS; i++) begin
          snap[i] = mem_i.mem[i];
        end
        snap_pattern = debug_e;
        snap_taken = 1'b1;
      end
      prev_oe_n = sram_oe_n;
      prev_we_n = sram_we_n;
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: no round finished within %0d cycles", CYCLE_LIMIT);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    int                          e0;
    sram_tester_pkg::addr_t      ref_addr;
    sram_tester_pkg::data_word_t ref_exp;
    sram_tester_pkg::data_word_t ref_rd;
    CLK = 1'b0;
    reset = 1'b1;
    fault_en = 1'b0;
    fault_addr = '0;
    fault_bit = '0;
    errors = 0;
    tests_run = 0;
    tests_bad = 0;
    lcg_state = 32'd3;

    e0 = errors;
    repeat (4) @(negedge CLK);
    check_flag("reset ce_n", 1'b1, sram_ce_n);
    check_flag("reset oe_n", 1'b1, sram_oe_n);
    check_flag("reset we_n", 1'b1, sram_we_n);
    check_flag("reset dq_oe", 1'b0, sram_dq_oe);
    check_flag("reset led_done", 1'b0, led_done);
    check_flag("reset led_pass", 1'b1, led_pass);
    repeat (4) @(negedge CLK);
    reset = 1'b0;
    @(negedge CLK);
    check_flag("post reset ce_n", 1'b1, sram_ce_n);
    check_flag("post reset we_n", 1'b1, sram_we_n);
    check_flag("post reset oe_n", 1'b1, sram_oe_n);
    check_flag("post reset dq_oe", 1'b0, sram_dq_oe);
    check_flag("post reset led_done", 1'b0, led_done);
    check_flag("post reset led_pass", 1'b1, led_pass);
    end_test("reset_state", e0);

    e0 = errors;
    wait_done();
    wait_done();
    repeat (3) @(negedge CLK);
    check_word("done pulses", 16'd2, 16'(round_reads.size()));
    foreach (round_reads[i]) begin
      check_word($sformatf("reads in round %0d", i), 16'(ROUND_READS), 16'(round_reads[i]));
    end
    check_flag("clean led_pass", 1'b1, led_pass);
    end_test("clean_rounds", e0);

    e0 = errors;
    check_flag("snapshot taken", 1'b1, snap_taken);
    check_word("debug_e pattern", {8'h00, mirrored_pattern(4)}, {8'h00, snap_pattern});
    for (int a = 0; a < sram_tester_pkg::NUM_WORDS; a++) begin
      check_word($sformatf("word %0d", a), pattern_ref(4, sram_tester_pkg::addr_t'(a)), snap[a]);
    end
    end_test("model_contents", e0);

    e0 = errors;
    lcg_state = lcg_next(lcg_state);
    fault_addr = sram_tester_pkg::addr_t'((lcg_state >> 16) % sram_tester_pkg::NUM_WORDS);
    lcg_state = lcg_next(lcg_state);
    // keep the stuck bit in the low byte that debug_j shows
    fault_bit = 4'((lcg_state >> 16) % 8);
    fault_en = 1'b1;
    apply_reset();
    while (led_pass) @(negedge CLK);
    repeat (3) @(negedge CLK);
    first_fail_ref(fault_addr, int'(fault_bit), ref_addr, ref_exp, ref_rd);
    check_flag("fault led_pass", 1'b0, led_pass);
    check_word("fault debug_i", {8'h00, ref_exp[7:0]}, {8'h00, debug_i});
    check_word("fault debug_j", {8'h00, ref_rd[7:0]}, {8'h00, debug_j});
    check_addr("fault address", ref_addr, decode_addr(debug_f, debug_h));
    end_test("stuck_fault", e0);

    e0 = errors;
    fault_en = 1'b0;
    apply_reset();
    @(negedge CLK);
    check_flag("recovered led_pass", 1'b1, led_pass);
    wait_done();
    @(negedge CLK);
    check_flag("recovery round led_pass", 1'b1, led_pass);
    check_word("recovery done pulses", 16'd1, 16'(round_reads.size()));
    foreach (round_reads[i]) begin
      check_word("recovery round reads", 16'(ROUND_READS), 16'(round_reads[i]));
    end
    end_test("recovery", e0);

    $display("tests run %0d, tests failed %0d, check errors %0d", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
hdl/sram_tester_pkg.sv
hdl/credit_fifo.sv
hdl/test_sequencer.sv
hdl/sram_controller.sv
hdl/result_checker.sv
hdl/status_display.sv
hdl/sram_tester_top.sv
tb/sram_model.sv
tb/sram_tester_props.sv
tb/sram_tester_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the SRAM tester testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module sram_tester_tb -f compile.f -o sram_tester_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output="$(./obj_dir/sram_tester_sim 2>&1)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
  exit 0
fi
exit 1
